/* common/spi_regs_params.svh */
`ifndef SPI_REGS_PARAMS_SVH
`define SPI_REGS_PARAMS_SVH

// bits in one valid configuration frame
// high byte address, low byte value
`define FRAME_BITS 16

// register map
// led bits
`define ADDR_LED 7
// peripheral select mask
`define ADDR_MUX 8
// dac control bits
`define ADDR_DAC 9

// width of peripheral select mask and chip select vector
// bit 0 dac, bit 1 adc
`define SEL_W 8

// upper bound in system cycles for any wait loop
// a frame takes about 8 cycles per bit
`define WAIT_LIMIT 2000

`endif

/* common/spi_regs_pkg.sv */
package spi_regs_pkg;

  // register address, high byte of a frame
  typedef logic [7:0] reg_addr_t;

  // register value, low byte of a frame
  typedef logic [7:0] reg_val_t;

  // one frame as shifted in, msb first
  // address ends up in the high byte
  typedef struct packed {
    reg_addr_t addr;
    reg_val_t  val;
  } spi_frame_t;

  // two leds on the board
  typedef logic [1:0] led_t;

  // dac control pins, board order
  // msb first
  typedef struct packed {
    logic uni_bip_b;
    logic uni_bip_a;
    logic dac_rst;
    logic ldac;
  } dac_ctrl_t;

endpackage

/* common/wb_if.sv */
`timescale 1ns/1ns

// wishbone classic, write only use
// single master, single slave
interface wb_if
  import spi_regs_pkg::*;
();

  // bus cycle in progress
  logic      cyc;
  // transfer strobe
  logic      stb;
  // write enable
  logic      we;
  // register address
  reg_addr_t adr;
  // write data
  reg_val_t  dat_w;
  // one cycle acknowledge from slave
  logic      ack;

  // frame receiver side
  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  ack
  );

  // register bank side
  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output ack
  );

endinterface

/* spi_rx/spi_frame_rx.sv */
`timescale 1ns/1ns

`include "spi_regs_params.svh"

module spi_frame_rx
  import spi_regs_pkg::*;
(
  input  logic cs,
  input  logic rst_n,
  input  logic spi_sclk,
  input  logic spi_ss_n,
  input  logic spi_mosi,
  input  logic spi_special,
  wb_if.master wb
);

  // bit counter saturates at all ones
  localparam int CNT_W = 5;
  localparam logic [CNT_W-1:0] CNT_MAX = '1;
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(`FRAME_BITS);
  // sync order {special, mosi, ss_n, sclk}
  // ss_n idles high so no false end of frame after reset
  localparam logic [3:0] SYNC_IDLE = 4'b0010;

  logic [3:0]       sync_q1;
  logic [3:0]       sync_q2;
  logic             sclk_s;
  logic             ss_n_s;
  logic             mosi_s;
  logic             special_s;
  logic             sclk_d;
  logic             ss_n_d;
  logic             sclk_fall;
  logic             ss_rise;
  logic             shift_en;
  logic             frame_ok;
  spi_frame_t       shift_q;
  logic [CNT_W-1:0] bit_cnt;

  // two flop synchronizers plus one delay stage for edges
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q1 <= SYNC_IDLE;
      sync_q2 <= SYNC_IDLE;
      sclk_d  <= 1'b0;
      ss_n_d  <= 1'b1;
    end
    else
    begin
      sync_q1 <= {spi_special, spi_mosi, spi_ss_n, spi_sclk};
      sync_q2 <= sync_q1;
      sclk_d  <= sclk_s;
      ss_n_d  <= ss_n_s;
    end
  end

  assign sclk_s    = sync_q2[0];
  assign ss_n_s    = sync_q2[1];
  assign mosi_s    = sync_q2[2];
  assign special_s = sync_q2[3];

  // data sampled on falling sclk
  assign sclk_fall = sclk_d && !sclk_s;
  // slave select released, frame done
  assign ss_rise   = !ss_n_d && ss_n_s;
  // only config frames shift, pass through traffic is ignored
  assign shift_en  = sclk_fall && !ss_n_s && !special_s;
  // exact length check, anything else is thrown away
  assign frame_ok  = ss_rise && (bit_cnt == CNT_FRAME) && !special_s;

  // shift register, msb first
  always_ff @(posedge cs)
  begin
    if (shift_en)
    begin
      shift_q <= spi_frame_t'({shift_q[`FRAME_BITS-2:0], mosi_s});
    end
  end

  // bit count, restarts at every frame end
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
    end
    else if (ss_rise)
    begin
      bit_cnt <= '0;
    end
    else if (shift_en && (bit_cnt != CNT_MAX))
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // wishbone master control
  // held until ack, frames arriving meanwhile are dropped
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb.cyc <= 1'b0;
      wb.stb <= 1'b0;
      wb.we  <= 1'b0;
    end
    else if (wb.cyc)
    begin
      if (wb.ack)
      begin
        wb.cyc <= 1'b0;
        wb.stb <= 1'b0;
        wb.we  <= 1'b0;
      end
    end
    else if (frame_ok)
    begin
      wb.cyc <= 1'b1;
      wb.stb <= 1'b1;
      wb.we  <= 1'b1;
    end
  end

  // address and data captured with the request
  always_ff @(posedge cs)
  begin
    if (frame_ok && !wb.cyc)
    begin
      wb.adr   <= shift_q.addr;
      wb.dat_w <= shift_q.val;
    end
  end

  // stb only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge cs) disable iff (!rst_n)
    wb.stb |-> wb.cyc)
    else $error("wishbone stb high without cyc");

  // request held steady until the slave answers
  a_req_stable: assert property (@(posedge cs) disable iff (!rst_n)
    (wb.stb && !wb.ack) |=> (wb.stb && $stable(wb.adr) && $stable(wb.dat_w)))
    else $error("wishbone request changed before ack");

endmodule

/* source/reg_bank.sv */
`timescale 1ns/1ns

`include "spi_regs_params.svh"

module reg_bank
  import spi_regs_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  wb_if.slave       wb,
  output reg_val_t  sel_mask,
  output led_t      led,
  output dac_ctrl_t dac_ctrl
);

  logic ack_q;
  logic wr_en;

  // write blocked in the ack cycle so one write per request
  assign wr_en = wb.cyc && wb.stb && wb.we && !ack_q;

  // registered ack one cycle after stb
  // low again in the next cycle even if stb is still up
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= wb.cyc && wb.stb && !ack_q;
    end
  end

  assign wb.ack = ack_q;

  // register writes commit with the ack
  // zero after reset leaves leds off and dac pins low with no peripheral selected
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sel_mask <= '0;
      led      <= '0;
      dac_ctrl <= '0;
    end
    else if (wr_en)
    begin
      case (wb.adr)
        // full byte mask
        reg_addr_t'(`ADDR_MUX):
        begin
          sel_mask <= wb.dat_w;
        end
        // two low bits only
        reg_addr_t'(`ADDR_LED):
        begin
          led <= led_t'(wb.dat_w[1:0]);
        end
        // four low bits in dac_ctrl_t order
        reg_addr_t'(`ADDR_DAC):
        begin
          dac_ctrl <= dac_ctrl_t'(wb.dat_w[3:0]);
        end
        // unknown address is acked and ignored
        default:
        begin
        end
      endcase
    end
  end

  // ack is a single pulse
  a_ack_pulse: assert property (@(posedge cs) disable iff (!rst_n)
    wb.ack |=> !wb.ack)
    else $error("wishbone ack high for two cycles");

endmodule

/* source/cs_router.sv */
`timescale 1ns/1ns

`include "spi_regs_params.svh"

module cs_router
  import spi_regs_pkg::*;
(
  input  logic              cs,
  input  logic              spi_sclk,
  input  logic              spi_ss_n,
  input  logic              spi_mosi,
  input  logic              spi_special,
  input  reg_val_t          sel_mask,
  output logic [`SEL_W-1:0] periph_cs_n,
  output logic              periph_sclk,
  output logic              periph_mosi
);

  logic [`SEL_W-1:0] sel_bits;
  logic              pass_en;

  // mask bits that map onto peripheral selects
  assign sel_bits = sel_mask[`SEL_W-1:0];

  // bus handed through only in special mode
  // and only with something selected
  assign pass_en = spi_special && !spi_ss_n && (|sel_bits);

  // purely combinational, no added delay on the peripheral clock
  always_comb
  begin
    if (spi_special)
    begin
      // low where the mask is set while ss_n is low
      periph_cs_n = ~(sel_bits & {`SEL_W{~spi_ss_n}});
    end
    else
    begin
      // config frame in progress, keep every peripheral off the bus
      periph_cs_n = '1;
    end
  end

  // clock and data parked low when not passing through
  assign periph_sclk = pass_en ? spi_sclk : 1'b0;
  assign periph_mosi = pass_en ? spi_mosi : 1'b0;

  // no peripheral ever sees a config frame
  a_idle_in_config: assert property (@(posedge cs)
    !spi_special |-> (&periph_cs_n))
    else $error("peripheral selected while special is low");

endmodule

/* source/panel_top.sv */
`timescale 1ns/1ns

`include "spi_regs_params.svh"

module panel_top
  import spi_regs_pkg::*;
(
  input  logic              cs,
  input  logic              rst_n,
  // microcontroller spi
  input  logic              spi_sclk,
  input  logic              spi_ss_n,
  input  logic              spi_mosi,
  input  logic              spi_special,
  // board leds
  output logic [1:0]        led,
  // {uni_bip_b, uni_bip_a, dac_rst, ldac}
  output logic [3:0]        dac_ctrl,
  // bit 0 dac, bit 1 adc, rest spare
  output logic [`SEL_W-1:0] periph_cs_n,
  output logic              periph_sclk,
  output logic              periph_mosi
);

  reg_val_t  sel_mask;
  led_t      led_q;
  dac_ctrl_t dac_q;

  // receiver to register bank
  wb_if u_wb ();

  // frame input, wishbone master
  spi_frame_rx u_rx (
    .cs          (cs),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_special (spi_special),
    .wb          (u_wb.master)
  );

  // mask, led and dac registers
  reg_bank u_regs (
    .cs       (cs),
    .rst_n    (rst_n),
    .wb       (u_wb.slave),
    .sel_mask (sel_mask),
    .led      (led_q),
    .dac_ctrl (dac_q)
  );

  // pass through to selected peripherals
  cs_router u_router (
    .cs          (cs),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_special (spi_special),
    .sel_mask    (sel_mask),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi)
  );

  // register fields out to the pins
  assign led      = led_q;
  assign dac_ctrl = dac_q;

endmodule

/* verification/panel_tb.sv */
`timescale 1ns/1ns

`include "spi_regs_params.svh"

module panel_tb
  import spi_regs_pkg::*;
;

  logic              cs;
  logic              rst_n;
  logic              spi_sclk;
  logic              spi_ss_n;
  logic              spi_mosi;
  logic              spi_special;
  logic [1:0]        led;
  logic [3:0]        dac_ctrl;
  logic [`SEL_W-1:0] periph_cs_n;
  logic              periph_sclk;
  logic              periph_mosi;

  // reference copy of the register bank
  reg_val_t          m_mask;
  led_t              m_led;
  logic [3:0]        m_dac;
  // high while a frame is on the way and outputs may lag the model
  logic              pending;
  logic              exp_sel;
  logic [`SEL_W-1:0] exp_cs_n;
  logic              exp_pass;
  logic [31:0]       rng_state;
  int                err_cnt;
  int                errs_at_start;
  int                test_cnt;
  int                test_fail;

  panel_top u_dut (
    .cs          (cs),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_mosi    (spi_mosi),
    .spi_special (spi_special),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi)
  );

  // 100 MHz system clock
  initial
  begin
    cs = 1'b0;
    forever #5 cs = ~cs;
  end

  // peripherals see the bus only in special mode with ss_n low
  assign exp_sel  = spi_special && !spi_ss_n;
  // selected ones are low, i.e. the inverted mask
  assign exp_cs_n = exp_sel ? ~m_mask : '1;
  assign exp_pass = exp_sel && (m_mask != '0);

  // register outputs against the model
  a_regs_match: assert property (@(posedge cs) disable iff (!rst_n || pending)
    (led == m_led) && (dac_ctrl == m_dac))
    else
    begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH at %0t: led %b dac_ctrl %b, expected led %b dac_ctrl %b",
        $time, led, dac_ctrl, m_led, m_dac);
    end

  // selects, clock and data against the model
  a_route_match: assert property (@(posedge cs) disable iff (!rst_n || pending)
    (periph_cs_n == exp_cs_n) && (periph_sclk == (exp_pass && spi_sclk)) &&
    (periph_mosi == (exp_pass && spi_mosi)))
    else
    begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH at %0t: periph_cs_n %b sclk %b mosi %b, expected cs_n %b",
        $time, periph_cs_n, periph_sclk, periph_mosi, exp_cs_n);
    end

  // config frames never reach a peripheral even mid frame
  a_config_idle: assert property (@(posedge cs) disable iff (!rst_n)
    !spi_special |-> (&periph_cs_n))
    else
    begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH at %0t: periph_cs_n %b while special is low", $time, periph_cs_n);
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic outputs_match();
    return (led == m_led) && (dac_ctrl == m_dac) && (periph_cs_n == exp_cs_n);
  endfunction

  // poll at the falling edge where outputs are settled
  task automatic wait_settle(input string what);
    int n;
    n = 0;
    @(negedge cs);
    while (!outputs_match() && (n < `WAIT_LIMIT))
    begin
      @(negedge cs);
      n = n + 1;
    end
    if (!outputs_match())
    begin
      $display("timeout: outputs did not settle after %s within %0d cycles", what, `WAIT_LIMIT);
      $display("test failed");
      $finish;
    end
  endtask

  // one spi transfer msb first with 4 cycle half periods
  // data changes on rising sclk and dut samples on falling sclk
  task automatic send_bits(input logic [31:0] data, input int nbits, input logic special);
    int        i;
    reg_addr_t addr;
    reg_val_t  val;
    @(posedge cs);
    pending     <= 1'b1;
    spi_special <= special;
    repeat (8) @(posedge cs);
    spi_ss_n <= 1'b0;
    repeat (4) @(posedge cs);
    for (i = nbits - 1; i >= 0; i--)
    begin
      spi_mosi <= data[i];
      spi_sclk <= 1'b1;
      repeat (4) @(posedge cs);
      spi_sclk <= 1'b0;
      repeat (4) @(posedge cs);
    end
    spi_ss_n <= 1'b1;
    // special held past the synchronized frame end
    repeat (8) @(posedge cs);
    spi_special <= 1'b0;
    spi_mosi    <= 1'b0;
    // only exact length config frames count
    if (!special && (nbits == `FRAME_BITS))
    begin
      addr = data[15:8];
      val  = data[7:0];
      case (addr)
        reg_addr_t'(`ADDR_MUX): m_mask = val;
        reg_addr_t'(`ADDR_LED): m_led  = val[1:0];
        reg_addr_t'(`ADDR_DAC): m_dac  = val[3:0];
        default: m_mask = m_mask;
      endcase
    end
    wait_settle("a frame");
    @(posedge cs);
    pending <= 1'b0;
    // frame spacing
    repeat (16) @(posedge cs);
  endtask

  // pass through traffic with special high
  task automatic pass_through(input int nclk);
    int       i;
    logic [31:0] r;
    @(posedge cs);
    spi_special <= 1'b1;
    repeat (4) @(posedge cs);
    spi_ss_n <= 1'b0;
    repeat (4) @(posedge cs);
    for (i = 0; i < nclk; i++)
    begin
      r = next_random();
      spi_mosi <= r[0];
      spi_sclk <= 1'b1;
      repeat (4) @(posedge cs);
      spi_sclk <= 1'b0;
      repeat (4) @(posedge cs);
    end
    spi_ss_n <= 1'b1;
    spi_mosi <= 1'b0;
    repeat (8) @(posedge cs);
    spi_special <= 1'b0;
    repeat (16) @(posedge cs);
  endtask

  // one report line per test
  task automatic end_test(input string name);
    test_cnt = test_cnt + 1;
    if (err_cnt == errs_at_start)
    begin
      $display("%s: ok", name);
    end
    else
    begin
      test_fail = test_fail + 1;
      $display("%s: FAILED, %0d mismatches", name, err_cnt - errs_at_start);
    end
    errs_at_start = err_cnt;
  endtask

  initial
  begin
    int          k;
    logic [31:0] r;
    reg_addr_t   addr;
    reg_val_t    val;
    rst_n         <= 1'b0;
    spi_sclk      <= 1'b0;
    spi_ss_n      <= 1'b1;
    spi_mosi      <= 1'b0;
    spi_special   <= 1'b0;
    pending       <= 1'b0;
    m_mask        = '0;
    m_led         = '0;
    m_dac         = '0;
    rng_state     = 32'd7644;
    err_cnt       = 0;
    errs_at_start = 0;
    test_cnt      = 0;
    test_fail     = 0;
    repeat (10) @(posedge cs);
    rst_n <= 1'b1;

    // leds off, dac low, nothing selected
    repeat (8) @(posedge cs);
    end_test("reset_values");

    // alternate led and dac writes
    for (k = 0; k < 8; k++)
    begin
      r    = next_random();
      addr = k[0] ? reg_addr_t'(`ADDR_DAC) : reg_addr_t'(`ADDR_LED);
      send_bits({16'h0000, addr, r[7:0]}, `FRAME_BITS, 1'b0);
    end
    end_test("register_writes");

    // long and short frames to the led register
    // the long frame ends in a zero bit
    // so a short frame taken whole would hit address 7
    r   = next_random();
    val = {r[7:2], ~m_led[1], 1'b0};
    send_bits({15'h0000, 1'b1, reg_addr_t'(`ADDR_LED), val}, 17, 1'b0);
    val = {r[7:2], ~m_led};
    send_bits({16'h0000, reg_addr_t'(`ADDR_LED), val}, 15, 1'b0);
    // unknown address frames
    for (k = 0; k < 3; k++)
    begin
      r    = next_random();
      addr = r[15:8];
      if ((addr >= reg_addr_t'(`ADDR_LED)) && (addr <= reg_addr_t'(`ADDR_DAC)))
      begin
        addr = addr ^ 8'h10;
      end
      send_bits({16'h0000, addr, r[7:0]}, `FRAME_BITS, 1'b0);
    end
    end_test("discarded_frames");

    // full frame in pass through mode
    r   = next_random();
    val = {r[7:4], ~m_dac};
    send_bits({16'h0000, reg_addr_t'(`ADDR_DAC), val}, `FRAME_BITS, 1'b1);
    end_test("special_frame_ignored");

    // random nonzero mask then traffic in both modes
    r   = next_random();
    val = r[7:0] | 8'h01;
    send_bits({16'h0000, reg_addr_t'(`ADDR_MUX), val}, `FRAME_BITS, 1'b0);
    pass_through(6);
    r = next_random();
    send_bits({16'h0000, reg_addr_t'(`ADDR_LED), r[7:0]}, `FRAME_BITS, 1'b0);
    pass_through(4);
    end_test("routing");

    $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
      test_cnt, test_cnt - test_fail, test_fail, err_cnt);
    if ((test_fail == 0) && (err_cnt == 0))
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/spi_regs_pkg.sv
common/wb_if.sv
spi_rx/spi_frame_rx.sv
source/reg_bank.sv
source/cs_router.sv
source/panel_top.sv
verification/panel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the panel testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module panel_tb -f vlog.f -o panel_sim \
  > build.log 2>&1 \
  && ./obj_dir/panel_sim > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "test failed" sim.log \
  && echo "simulation PASS" \
  || { cat build.log sim.log 2>/dev/null; echo "simulation FAIL"; exit 1; }
